// File: design/bus_pkg.sv
`default_nettype none

// bus-side definitions of the console write port
package bus_pkg;

	// write data word width
	localparam int data_w = 32;

	// write response codes
	localparam logic [1:0] resp_okay = 2'b00; // the only code the port ever returns
	localparam logic [1:0] resp_none = 2'b11; // shown while no response is pending

	// write response channel
	// resp is only meaningful while valid is high
	typedef struct packed {
		logic [1:0] resp;
		logic       valid;
	} bresp_t;

endpackage

`default_nettype wire

// File: design/console_pkg.sv
`default_nettype none

// console-side definitions: response delay and character output
package console_pkg;

	// width of the response delay, also the shift register width
	localparam int dly_w = 4;

	// shift register start value, must be nonzero
	localparam logic [dly_w-1:0] lfsr_seed = 4'h1;

	// response delay selection
	typedef struct packed {
		logic             rand_en;   // take the delay from the shift register
		logic [dly_w-1:0] fixed_dly; // cycles added before the response
	} delay_cfg_t;

	// character output, one strobe per accepted write
	typedef struct packed {
		logic       strobe;
		logic [7:0] data;  // low byte of the write data
	} tx_byte_t;

endpackage

`default_nettype wire

// File: design/write_acceptor.sv
`timescale 1ns/1ps
`default_nettype none

// idle/busy handshake FSM of the console write port
// takes address and data strobes in the same cycle, emits the low byte
module write_acceptor (
	input  logic                       clk_i,
	input  logic                       rstn_i,         // sync, active high
	input  logic                       addr_w_valid_i,
	input  logic                       w_valid_i,
	input  logic [bus_pkg::data_w-1:0] w_data_i,
	input  logic                       rsp_done_i,     // response taken by master
	output logic                       ready_o,
	output logic                       accept_o,
	output logic                       busy_o,
	output console_pkg::tx_byte_t      tx_o
);

	typedef enum logic {
		st_idle,
		st_busy
	} state_t;

	state_t     state_q;
	state_t     state_d;
	logic       tx_stb_q;
	logic [7:0] tx_data_q;

	// one ready level serves both address and data channels
	assign ready_o = (state_q == st_idle);
	assign busy_o  = (state_q == st_busy);

	// a lone valid just waits here
	assign accept_o = ready_o & addr_w_valid_i & w_valid_i;

	always_comb begin
		state_d = state_q;
		case (state_q)
			st_idle: begin
				if (accept_o) begin
					state_d = st_busy;
				end
			end
			st_busy: begin
				// back to idle once the response is taken
				if (rsp_done_i) begin
					state_d = st_idle;
				end
			end
			default: begin
				state_d = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rstn_i) begin
			state_q  <= st_idle;
			tx_stb_q <= 1'b0;
		end else begin
			state_q  <= state_d;
			tx_stb_q <= accept_o; // high for the single cycle after accept
		end
	end

	// character captured on the accept edge
	always_ff @(posedge clk_i) begin
		if (accept_o) begin
			tx_data_q <= w_data_i[7:0];
		end
	end

	assign tx_o.strobe = tx_stb_q;
	assign tx_o.data   = tx_data_q;

	// done comes from the response timer, must match a held write
	a_done_while_busy: assert property (
		@(posedge clk_i) disable iff (rstn_i)
		rsp_done_i |-> busy_o
	) else $error("write_acceptor: response done while idle");

endmodule

`default_nettype wire

// File: design/delay_lfsr.sv
`timescale 1ns/1ps
`default_nettype none

// 4-bit fibonacci shift register, x^4+x^3+1
// current value is the random delay of the write being accepted
module delay_lfsr (
	input  logic                          clk_i,
	input  logic                          rstn_i,  // sync, active high
	input  logic                          step_i,  // accept pulse
	output logic [console_pkg::dly_w-1:0] value_o
);

	logic [console_pkg::dly_w-1:0] lfsr_q;
	logic                          feedback;

	assign feedback = lfsr_q[3] ^ lfsr_q[2]; // taps of x^4+x^3+1

	always_ff @(posedge clk_i) begin
		if (rstn_i) begin
			lfsr_q <= console_pkg::lfsr_seed;
		end else if (step_i) begin
			// shift left, feedback into bit 0
			lfsr_q <= {lfsr_q[console_pkg::dly_w-2:0], feedback};
		end
	end

	assign value_o = lfsr_q;

	// a zero state would lock the register for good
	a_never_zero: assert property (
		@(posedge clk_i) disable iff (rstn_i)
		value_o != '0
	) else $error("delay_lfsr: register reached zero");

endmodule

`default_nettype wire

// File: design/resp_timer.sv
`timescale 1ns/1ps
`default_nettype none

// write response timer
// latches the delay on accept, counts up to it, then holds the
// response valid until the master takes it
module resp_timer (
	input  logic                          clk_i,
	input  logic                          rstn_i,       // sync, active high
	input  logic                          accept_i,
	input  logic [console_pkg::dly_w-1:0] rand_dly_i,   // shift register value
	input  console_pkg::delay_cfg_t       delay_cfg_i,
	input  logic                          bkwd_ready_i,
	output bus_pkg::bresp_t               bresp_o,
	output logic                          rsp_done_o
);

	logic                          active_q;   // a write is waiting for its response
	logic [console_pkg::dly_w-1:0] cnt_q;
	logic [console_pkg::dly_w-1:0] dly_q;
	logic [console_pkg::dly_w-1:0] dly_sel;
	logic                          at_target;

	// delay for the write being accepted
	assign dly_sel = delay_cfg_i.rand_en ? rand_dly_i : delay_cfg_i.fixed_dly;

	// D = 0 gives a valid in the first cycle after accept
	assign at_target = active_q && (cnt_q == dly_q);

	always_ff @(posedge clk_i) begin
		if (rstn_i) begin
			active_q <= 1'b0;
			cnt_q    <= '0;
			dly_q    <= '0;
		end else if (accept_i) begin
			active_q <= 1'b1;
			cnt_q    <= '0;
			dly_q    <= dly_sel;
		end else if (rsp_done_o) begin
			active_q <= 1'b0;
			cnt_q    <= '0;
		end else if (active_q && !at_target) begin
			cnt_q <= cnt_q + 1'b1;
		end
		// at target and not taken, everything holds
	end

	assign bresp_o.valid = at_target;
	assign bresp_o.resp  = at_target ? bus_pkg::resp_okay : bus_pkg::resp_none;

	// the only place the response handshake is decided
	assign rsp_done_o = at_target & bkwd_ready_i;

	// back-pressure holds valid and code
	a_valid_held: assert property (
		@(posedge clk_i) disable iff (rstn_i)
		(bresp_o.valid && !bkwd_ready_i) |=>
			(bresp_o.valid && bresp_o.resp == bus_pkg::resp_okay)
	) else $error("resp_timer: response dropped before it was taken");

	// acceptor must not admit a second write while one is pending
	a_one_in_flight: assert property (
		@(posedge clk_i) disable iff (rstn_i)
		accept_i |-> !active_q
	) else $error("resp_timer: accept while a response is pending");

endmodule

`default_nettype wire

// File: design/console_wr_port.sv
`timescale 1ns/1ps
`default_nettype none

// console write port: write-only bus slave, one character per write
module console_wr_port (
	input  logic                       clk,
	input  logic                       rstn,           // sync, active high

	// address write
	input  logic                       addr_w_valid_i,
	output logic                       addr_w_ready_o,

	// write data, only the low byte is used
	input  logic [bus_pkg::data_w-1:0] w_data_i,
	input  logic                       w_valid_i,
	output logic                       w_ready_o,

	// write response
	output bus_pkg::bresp_t            bresp_o,
	input  logic                       bkwd_ready_i,

	input  console_pkg::delay_cfg_t    delay_cfg_i,
	output console_pkg::tx_byte_t      tx_o
);

	logic                          ready;
	logic                          accept;
	logic                          busy;
	logic                          rsp_done;
	logic [console_pkg::dly_w-1:0] rand_dly;

	assign addr_w_ready_o = ready;
	assign w_ready_o      = ready; // same level on both channels

	write_acceptor write_acceptor_i (
		.clk_i          (clk),
		.rstn_i         (rstn),
		.addr_w_valid_i (addr_w_valid_i),
		.w_valid_i      (w_valid_i),
		.w_data_i       (w_data_i),
		.rsp_done_i     (rsp_done),
		.ready_o        (ready),
		.accept_o       (accept),
		.busy_o         (busy),
		.tx_o           (tx_o)
	);

	delay_lfsr delay_lfsr_i (
		.clk_i   (clk),
		.rstn_i  (rstn),
		.step_i  (accept),
		.value_o (rand_dly)
	);

	resp_timer resp_timer_i (
		.clk_i        (clk),
		.rstn_i       (rstn),
		.accept_i     (accept),
		.rand_dly_i   (rand_dly),
		.delay_cfg_i  (delay_cfg_i),
		.bkwd_ready_i (bkwd_ready_i),
		.bresp_o      (bresp_o),
		.rsp_done_o   (rsp_done)
	);

	// a response only exists for a write the acceptor is holding
	a_valid_while_busy: assert property (
		@(posedge clk) disable iff (rstn)
		bresp_o.valid |-> busy
	) else $error("console_wr_port: response valid with no write held");

endmodule

`default_nettype wire

// File: sim/tb_console_wr_port.sv
`timescale 1ns/1ps
`default_nettype none

// table-driven testbench for the console write port
module tb_console_wr_port;

	localparam int num_rows = 10;

	// one write of the stimulus table
	typedef struct packed {
		logic [31:0]             data;
		logic                    rand_byte; // low byte comes from $urandom
		console_pkg::delay_cfg_t cfg;
		logic [3:0]              gap;       // cycles from address valid to data valid
		logic [3:0]              bp;        // cycles the master holds off the response
	} row_t;

	logic                    clk;
	logic                    rstn;
	logic                    addr_w_valid;
	logic                    addr_w_ready;
	logic [31:0]             w_data;
	logic                    w_valid;
	logic                    w_ready;
	bus_pkg::bresp_t         bresp;
	logic                    bkwd_ready;
	console_pkg::delay_cfg_t delay_cfg;
	console_pkg::tx_byte_t   tx;

	row_t        rows [num_rows];
	int          err_cnt = 0;
	int          rows_failed = 0;
	int          cycle_cnt = 0;
	int          cycle_limit = 0;
	int          strobe_cnt;
	logic [3:0]  lfsr_model; // expected shift register value

	console_wr_port console_wr_port_i (
		.clk            (clk),
		.rstn           (rstn),
		.addr_w_valid_i (addr_w_valid),
		.addr_w_ready_o (addr_w_ready),
		.w_data_i       (w_data),
		.w_valid_i      (w_valid),
		.w_ready_o      (w_ready),
		.bresp_o        (bresp),
		.bkwd_ready_i   (bkwd_ready),
		.delay_cfg_i    (delay_cfg),
		.tx_o           (tx)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	// watchdog
	initial begin
		wait (cycle_limit != 0 && cycle_cnt > cycle_limit);
		$display("timeout: the run went past %0d cycles without finishing", cycle_limit);
		$display("TEST FAILED");
		$finish;
	end

	task automatic compare_val(input logic [31:0] got, input logic [31:0] exp,
			input string what);
		if (got !== exp) begin
			$display("[FAIL] %0t: %s, got %0h, expected %0h", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	// outputs are settled 1 ns after the edge, inputs change right after sampling
	task automatic step_clk();
		@(posedge clk);
		#1;
		if (tx.strobe) begin
			strobe_cnt++;
		end
	endtask

	// x^4+x^3+1, shift left with the new bit from taps 3 and 2
	function automatic logic [3:0] lfsr_next(input logic [3:0] v);
		return {v[2:0], v[3] ^ v[2]};
	endfunction

	task automatic run_write(input int idx);
		row_t        r;
		logic [31:0] data;
		logic [3:0]  dly;
		int          errs_before;
		int          g;
		int          c;
		int          b;
		r = rows[idx];
		errs_before = err_cnt;
		strobe_cnt = 0;
		data = r.data;
		if (r.rand_byte) begin
			data[7:0] = 8'($urandom);
		end
		dly = r.cfg.rand_en ? lfsr_model : r.cfg.fixed_dly;

		delay_cfg = r.cfg;
		w_data = data;
		addr_w_valid = 1'b1;
		w_valid = (r.gap == 0);
		for (g = 0; g < int'(r.gap); g++) begin
			step_clk();
			compare_val(addr_w_ready, 1, "ready while data valid is low");
			compare_val(tx.strobe, 0, "tx strobe before data valid");
			if (g == int'(r.gap) - 1) begin
				w_valid = 1'b1;
			end
		end

		step_clk(); // accept edge
		lfsr_model = lfsr_next(lfsr_model); // steps on every accept
		compare_val(tx.strobe, 1, "tx strobe after accept");
		compare_val(tx.data, data[7:0], "tx byte");
		compare_val(addr_w_ready, 0, "address ready after accept");
		compare_val(w_ready, 0, "data ready after accept");
		addr_w_valid = 1'b0;
		w_valid = 1'b0;

		// c counts cycles after the accept, valid is due at c = D+1
		c = 1;
		while (c < int'(dly) + 1) begin
			compare_val(bresp.valid, 0, "response valid before the delay");
			compare_val(bresp.resp, 2'b11, "response code with no response");
			compare_val(addr_w_ready, 0, "ready while waiting for response");
			bkwd_ready = 1'($urandom); // no effect until valid is up
			step_clk();
			c++;
		end
		compare_val(bresp.valid, 1, "response valid at the delay");
		compare_val(bresp.resp, 2'b00, "response code OKAY");

		bkwd_ready = (r.bp == 0);
		for (b = 1; b <= int'(r.bp); b++) begin
			step_clk();
			compare_val(bresp.valid, 1, "valid held under back-pressure");
			compare_val(bresp.resp, 2'b00, "code held under back-pressure");
			compare_val(w_ready, 0, "ready low under back-pressure");
			bkwd_ready = (b == int'(r.bp));
		end

		step_clk(); // response taken here
		bkwd_ready = 1'b0;
		compare_val(bresp.valid, 0, "valid after the response was taken");
		compare_val(bresp.resp, 2'b11, "code after the response was taken");
		compare_val(addr_w_ready, 1, "address ready after the response");
		compare_val(w_ready, 1, "data ready after the response");
		compare_val(strobe_cnt, 1, "tx strobes for one write");

		if (err_cnt == errs_before) begin
			$display("row %0d: ok, byte %02h, delay %0d, hold %0d", idx, data[7:0], dly, r.bp);
		end else begin
			rows_failed++;
			$display("row %0d: failed, byte %02h, delay %0d, hold %0d",
				idx, data[7:0], dly, r.bp);
		end
	endtask

	initial begin
		void'($urandom(32'h2fa4));
		rstn = 1'b1;
		addr_w_valid = 1'b0;
		w_valid = 1'b0;
		w_data = '0;
		bkwd_ready = 1'b0;
		delay_cfg = '0;
		lfsr_model = 4'h1;

		// random rows first, so the first write sees the seed
		rows[0] = '{32'h0000_0048, 1'b0, '{1'b1, 4'd0}, 4'd0, 4'd0};
		rows[1] = '{32'h1111_1165, 1'b0, '{1'b1, 4'd7}, 4'd0, 4'd1};
		rows[2] = '{32'h2222_226c, 1'b1, '{1'b1, 4'd0}, 4'd0, 4'd0};
		rows[3] = '{32'h3333_336f, 1'b0, '{1'b1, 4'd2}, 4'd2, 4'd0};
		rows[4] = '{32'ha5a5_0020, 1'b0, '{1'b0, 4'd0}, 4'd0, 4'd0};
		rows[5] = '{32'h1234_5657, 1'b0, '{1'b0, 4'd3}, 4'd0, 4'd3};
		rows[6] = '{32'hdead_be6f, 1'b0, '{1'b0, 4'd15}, 4'd0, 4'd0};
		rows[7] = '{32'hcafe_0072, 1'b1, '{1'b0, 4'd0}, 4'd5, 4'd4};
		rows[8] = '{32'h0bad_f06c, 1'b0, '{1'b0, 4'd5}, 4'd1, 4'd0};
		rows[9] = '{32'h5555_5564, 1'b1, '{1'b1, 4'd9}, 4'd0, 4'd2};

		// worst row: gap, accept, 16 delay cycles, hold, take edge
		cycle_limit = 10 + 40;
		for (int i = 0; i < num_rows; i++) begin
			cycle_limit = cycle_limit + int'(rows[i].gap) + int'(rows[i].bp) + 20;
		end

		repeat (10) @(posedge clk);
		#1;
		rstn = 1'b0;
		compare_val(addr_w_ready, 1, "address ready after reset");
		compare_val(w_ready, 1, "data ready after reset");
		compare_val(bresp.valid, 0, "response valid after reset");
		compare_val(bresp.resp, 2'b11, "response code after reset");
		compare_val(tx.strobe, 0, "tx strobe after reset");
		if (err_cnt == 0) begin
			$display("reset: ok");
		end else begin
			$display("reset: failed");
		end

		for (int i = 0; i < num_rows; i++) begin
			run_write(i);
		end

		$display("done: %0d rows run, %0d rows failed, %0d checks failed",
			num_rows, rows_failed, err_cnt);
		if (err_cnt == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
design/bus_pkg.sv
design/console_pkg.sv
design/write_acceptor.sv
design/delay_lfsr.sv
design/resp_timer.sv
design/console_wr_port.sv
sim/tb_console_wr_port.sv

// File: run_sim.sh
#!/bin/sh
# build and run the console write port testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "cannot enter the project directory"
	exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
	-f tb.f \
	--top-module tb_console_wr_port \
	-Mdir obj_dir \
	-o sim_console
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_console)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

printf '%s\n' "$output" | grep -qx "TEST PASSED"
if [ $? -ne 0 ]; then
	echo "pass message not found"
	exit 1
fi

exit 0
